// ==== video_defs.svh ====
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// ==========================================================================
// Raster geometry, kept tiny for short simulations
// ==========================================================================
`define VID_H_ACTIVE     8   // Pixels per active line
`define VID_V_ACTIVE     2   // Active lines per frame
`define VID_H_SYNC       2   // Hsync width in cycles
`define VID_H_BACK       2   // Cycles between hsync and first pixel
`define VID_H_FRONT      2   // Cycles after last pixel
`define VID_V_SYNC       1   // Vsync width in lines
`define VID_V_BACK       1   // Blank lines after vsync
`define VID_V_FRONT      1   // Blank lines at frame end

// ==========================================================================
// Frame store sizing
// ==========================================================================
`define VID_FRAME_WORDS  16  // One Y/C word per pixel
`define VID_ADDR_W       4   // Word address inside one bank

// Fixed pipeline depths of the colour converters
`define VID_TO_YUV_LAT   2   // Products, then sums
`define VID_TO_RGB_LAT   3   // Capture, pair chroma, convert

`endif

// ==== video_pkg.sv ====
package video_pkg;

  typedef logic [7:0]  t_chan;     // One colour or Y/C channel
  typedef logic [15:0] t_yc_word;  // Luma high byte and chroma low byte

  // Chroma carried by a packed word
  typedef enum logic {
    CHROMA_CB = 1'b0,              // Even pixel of a pair
    CHROMA_CR = 1'b1               // Odd pixel of a pair
  } t_chroma_sel;

  // Phase of one raster axis
  typedef enum logic [1:0] {
    PH_SYNC   = 2'd0,
    PH_BACK   = 2'd1,
    PH_ACTIVE = 2'd2,
    PH_FRONT  = 2'd3
  } t_sync_phase;

endpackage

// ==== rgb_to_yuv422.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module rgb_to_yuv422
(
  input  logic                sys_clk,
  input  logic                Sys_Rst_N,
  input  logic                i_vs,        // Frame start pulse
  input  logic                i_de,        // Pixel strobe
  input  video_pkg::t_chan    i_r,
  input  video_pkg::t_chan    i_g,
  input  video_pkg::t_chan    i_b,
  output logic                o_vs,
  output logic                o_de,
  output video_pkg::t_yc_word o_yc         // Y with Cb or Cr
);
  import video_pkg::*;

  logic [15:0] y_r, y_g, y_b;              // Luma products
  logic [15:0] cb_r, cb_g, cb_b;           // Blue difference products
  logic [15:0] cr_r, cr_g, cr_b;           // Red difference products
  logic [15:0] y_sum;
  logic [15:0] cb_sum;                     // Two's complement, top byte is floor
  logic [15:0] cr_sum;
  t_chan       y_val;
  t_chan       c_val;
  t_chroma_sel parity;                     // Chroma of next input pixel
  t_chroma_sel sel1;                       // Chroma of pixel in stage one
  logic [`VID_TO_YUV_LAT-1:0] vs_sr;
  logic [`VID_TO_YUV_LAT-1:0] de_sr;

  // ==========================================================================
  // Stage one, weighted products
  // ==========================================================================
  always_ff @(posedge sys_clk)
  begin
    y_r  <= 16'd66 * i_r;
    y_g  <= 16'd129 * i_g;
    y_b  <= 16'd25 * i_b;
    cb_r <= 16'd38 * i_r;
    cb_g <= 16'd74 * i_g;
    cb_b <= 16'd112 * i_b;
    cr_r <= 16'd112 * i_r;
    cr_g <= 16'd94 * i_g;
    cr_b <= 16'd18 * i_b;
  end

  always_ff @(posedge sys_clk or negedge Sys_Rst_N)
  begin
    if (!Sys_Rst_N)
    begin
      parity <= CHROMA_CB;
      sel1   <= CHROMA_CB;
      vs_sr  <= '0;
      de_sr  <= '0;
    end
    else
    begin
      sel1  <= i_vs ? CHROMA_CB : parity;  // New frame starts even
      vs_sr <= {vs_sr[`VID_TO_YUV_LAT-2:0], i_vs};
      de_sr <= {de_sr[`VID_TO_YUV_LAT-2:0], i_de};
      if (i_vs)
        parity <= i_de ? CHROMA_CR : CHROMA_CB;
      else if (i_de)
        parity <= (parity == CHROMA_CB) ? CHROMA_CR : CHROMA_CB;
    end
  end

  // ==========================================================================
  // Stage two, sums and offsets
  // ==========================================================================
  assign y_sum  = y_r + y_g + y_b + 16'd128;
  assign cb_sum = cb_b - cb_r - cb_g + 16'd128;   // Stays within 16 bit signed
  assign cr_sum = cr_r - cr_g - cr_b + 16'd128;
  assign y_val  = y_sum[15:8] + 8'd16;
  assign c_val  = (sel1 == CHROMA_CB) ? cb_sum[15:8] + 8'd128 : cr_sum[15:8] + 8'd128;

  always_ff @(posedge sys_clk)
  begin
    o_yc <= {y_val, c_val};
  end

  assign o_vs = vs_sr[`VID_TO_YUV_LAT-1];         // Matched to data
  assign o_de = de_sr[`VID_TO_YUV_LAT-1];

endmodule

// ==== frame_store.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module frame_store
(
  input  logic                sys_clk,
  input  logic                Sys_Rst_N,
  input  logic                i_wr_vs,      // Closes the frame being written
  input  logic                i_wr_de,
  input  video_pkg::t_yc_word i_wr_yc,
  input  logic                i_rd_vs,      // From timing generator
  input  logic                i_rd_hs,
  input  logic                i_rd_de,
  output logic                o_frame_avail,
  output logic                o_rd_vs,
  output logic                o_rd_hs,
  output logic                o_rd_de,
  output video_pkg::t_yc_word o_rd_yc
);
  import video_pkg::*;

  t_yc_word mem [0:2*`VID_FRAME_WORDS-1];   // Bank is the address MSB
  logic                   wr_bank;          // Bank being filled
  logic [`VID_ADDR_W-1:0] wr_addr;
  logic                   wr_dirty;         // Write bank holds pixels
  logic                   done_bank;        // Latest complete frame
  logic                   rd_bank;          // Bank shown this output frame
  logic [`VID_ADDR_W-1:0] rd_addr;

  // ==========================================================================
  // Write side
  // ==========================================================================
  always_ff @(posedge sys_clk)
  begin
    if (i_wr_de && !i_wr_vs)
      mem[{wr_bank, wr_addr}] <= i_wr_yc;
  end

  always_ff @(posedge sys_clk or negedge Sys_Rst_N)
  begin
    if (!Sys_Rst_N)
    begin
      wr_bank       <= 1'b0;
      wr_addr       <= '0;
      wr_dirty      <= 1'b0;
      done_bank     <= 1'b0;
      o_frame_avail <= 1'b0;
    end
    else if (i_wr_vs)
    begin
      if (wr_dirty)                         // First vs has nothing to close
      begin
        done_bank     <= wr_bank;
        wr_bank       <= ~wr_bank;
        o_frame_avail <= 1'b1;              // Sticky
      end
      wr_addr  <= '0;
      wr_dirty <= 1'b0;
    end
    else if (i_wr_de)
    begin
      wr_addr  <= wr_addr + 1'b1;
      wr_dirty <= 1'b1;
    end
  end

  // ==========================================================================
  // Read side
  // ==========================================================================
  always_ff @(posedge sys_clk or negedge Sys_Rst_N)
  begin
    if (!Sys_Rst_N)
    begin
      rd_bank <= 1'b0;
      rd_addr <= '0;
      o_rd_vs <= 1'b0;
      o_rd_hs <= 1'b0;
      o_rd_de <= 1'b0;
    end
    else
    begin
      o_rd_vs <= i_rd_vs;
      o_rd_hs <= i_rd_hs;
      o_rd_de <= i_rd_de;
      if (i_rd_vs && !o_rd_vs)
        rd_bank <= done_bank;               // Bank fixed at frame start
      if (i_rd_vs)
        rd_addr <= '0;
      else if (i_rd_de)
        rd_addr <= rd_addr + 1'b1;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    o_rd_yc <= mem[{rd_bank, rd_addr}];     // Aligned with delayed sync
  end

endmodule

// ==== video_timing_gen.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module video_timing_gen
(
  input  logic sys_clk,
  input  logic Sys_Rst_N,
  input  logic i_frame_avail,     // Store holds a complete frame
  output logic o_hs,
  output logic o_vs,
  output logic o_de
);
  import video_pkg::*;

  t_sync_phase h_state;
  t_sync_phase v_state;
  logic [3:0]  h_cnt;             // Cycles inside h phase
  logic [3:0]  v_cnt;             // Lines inside v phase
  logic [3:0]  h_len;
  logic [3:0]  v_len;
  logic        h_last;
  logic        v_last;
  logic        line_end;
  logic        run;               // Start flag

  function automatic t_sync_phase next_phase(input t_sync_phase ph);
    case (ph)
      PH_SYNC:   return PH_BACK;
      PH_BACK:   return PH_ACTIVE;
      PH_ACTIVE: return PH_FRONT;
      default:   return PH_SYNC;
    endcase
  endfunction

  // Phase lengths
  always_comb
  begin
    case (h_state)
      PH_SYNC:   h_len = 4'(`VID_H_SYNC);
      PH_BACK:   h_len = 4'(`VID_H_BACK);
      PH_ACTIVE: h_len = 4'(`VID_H_ACTIVE);
      default:   h_len = 4'(`VID_H_FRONT);
    endcase
    case (v_state)
      PH_SYNC:   v_len = 4'(`VID_V_SYNC);
      PH_BACK:   v_len = 4'(`VID_V_BACK);
      PH_ACTIVE: v_len = 4'(`VID_V_ACTIVE);
      default:   v_len = 4'(`VID_V_FRONT);
    endcase
  end

  assign h_last   = (h_cnt == h_len - 4'd1);
  assign v_last   = (v_cnt == v_len - 4'd1);
  assign line_end = h_last && (h_state == PH_FRONT);

  // ==========================================================================
  // Horizontal and vertical FSMs
  // ==========================================================================
  always_ff @(posedge sys_clk or negedge Sys_Rst_N)
  begin
    if (!Sys_Rst_N)
    begin
      run     <= 1'b0;
      h_state <= PH_SYNC;         // Frame begins in vsync line
      h_cnt   <= '0;
      v_state <= PH_SYNC;
      v_cnt   <= '0;
    end
    else
    begin
      if (i_frame_avail)
        run <= 1'b1;
      if (run)
      begin
        h_cnt <= h_last ? 4'd0 : h_cnt + 4'd1;
        if (h_last)
          h_state <= next_phase(h_state);
        if (line_end)             // Vertical steps once per line
        begin
          v_cnt <= v_last ? 4'd0 : v_cnt + 4'd1;
          if (v_last)
            v_state <= next_phase(v_state);
        end
      end
    end
  end

  assign o_hs = run && (h_state == PH_SYNC);
  assign o_vs = run && (v_state == PH_SYNC);
  assign o_de = run && (h_state == PH_ACTIVE) && (v_state == PH_ACTIVE);

endmodule

// ==== yuv422_to_rgb.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module yuv422_to_rgb
(
  input  logic                sys_clk,
  input  logic                Sys_Rst_N,
  input  logic                i_vs,
  input  logic                i_hs,
  input  logic                i_de,
  input  video_pkg::t_yc_word i_yc,
  output logic                o_vs,
  output logic                o_hs,
  output logic                o_de,
  output video_pkg::t_chan    o_r,
  output video_pkg::t_chan    o_g,
  output video_pkg::t_chan    o_b
);
  import video_pkg::*;

  t_yc_word           yc1;          // Stage one word
  t_chroma_sel        sel1;         // Its place in the pair
  t_chroma_sel        parity;
  t_chan              y2, cb2, cr2; // Pixel with shared chroma
  t_chan              cb_hold;      // Cb of the even pixel
  logic signed [9:0]  y_t, cb_t, cr_t;
  logic signed [19:0] r_sum, g_sum, b_sum;
  logic [`VID_TO_RGB_LAT-1:0] vs_sr, hs_sr, de_sr;

  function automatic t_chan clip8(input logic signed [19:0] v);
    if (v[19])
      return 8'd0;                  // Below black
    else if (|v[18:16])
      return 8'd255;                // Above white
    else
      return v[15:8];
  endfunction

  always_ff @(posedge sys_clk or negedge Sys_Rst_N)
  begin
    if (!Sys_Rst_N)
    begin
      parity <= CHROMA_CB;
      sel1   <= CHROMA_CB;
      vs_sr  <= '0;
      hs_sr  <= '0;
      de_sr  <= '0;
    end
    else
    begin
      sel1  <= parity;
      vs_sr <= {vs_sr[`VID_TO_RGB_LAT-2:0], i_vs};
      hs_sr <= {hs_sr[`VID_TO_RGB_LAT-2:0], i_hs};
      de_sr <= {de_sr[`VID_TO_RGB_LAT-2:0], i_de};
      if (i_vs)
        parity <= CHROMA_CB;
      else if (i_de)
        parity <= (parity == CHROMA_CB) ? CHROMA_CR : CHROMA_CB;
    end
  end

  // ==========================================================================
  // Capture and chroma pairing
  // ==========================================================================
  always_ff @(posedge sys_clk)
  begin
    yc1 <= i_yc;
    y2  <= yc1[15:8];
    if (sel1 == CHROMA_CB)          // Odd partner is at the input now
    begin
      cb2     <= yc1[7:0];
      cr2     <= i_yc[7:0];
      cb_hold <= yc1[7:0];
    end
    else
    begin
      cb2 <= cb_hold;
      cr2 <= yc1[7:0];
    end
  end

  // ==========================================================================
  // BT.601 expansion
  // ==========================================================================
  assign y_t   = $signed({2'b00, y2}) - 10'sd16;
  assign cb_t  = $signed({2'b00, cb2}) - 10'sd128;
  assign cr_t  = $signed({2'b00, cr2}) - 10'sd128;
  assign r_sum = 20'sd298 * y_t + 20'sd409 * cr_t + 20'sd128;
  assign g_sum = 20'sd298 * y_t - 20'sd100 * cb_t - 20'sd208 * cr_t + 20'sd128;
  assign b_sum = 20'sd298 * y_t + 20'sd516 * cb_t + 20'sd128;

  always_ff @(posedge sys_clk)
  begin
    o_r <= clip8(r_sum);
    o_g <= clip8(g_sum);
    o_b <= clip8(b_sum);
  end

  assign o_vs = vs_sr[`VID_TO_RGB_LAT-1];
  assign o_hs = hs_sr[`VID_TO_RGB_LAT-1];
  assign o_de = de_sr[`VID_TO_RGB_LAT-1];

endmodule

// ==== video_top.sv ====
`timescale 1ns/1ns

module video_top
(
  input  logic             sys_clk,
  input  logic             Sys_Rst_N,
  input  logic             i_vs,       // Input frame start
  input  logic             i_de,
  input  video_pkg::t_chan i_r,
  input  video_pkg::t_chan i_g,
  input  video_pkg::t_chan i_b,
  output logic             o_vs,       // Output raster
  output logic             o_hs,
  output logic             o_de,
  output video_pkg::t_chan o_r,
  output video_pkg::t_chan o_g,
  output video_pkg::t_chan o_b
);
  import video_pkg::*;

  logic     wr_vs, wr_de;              // Packed stream into store
  t_yc_word wr_yc;
  logic     frame_avail;
  logic     tg_vs, tg_hs, tg_de;       // Raster from timing FSMs
  logic     rd_vs, rd_hs, rd_de;       // Store output, one cycle later
  t_yc_word rd_yc;

  // ==========================================================================
  // Producer, store, consumer
  // ==========================================================================
  rgb_to_yuv422 u_rgb_to_yuv422 (
    .sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
    .i_vs (i_vs), .i_de (i_de), .i_r (i_r), .i_g (i_g), .i_b (i_b),
    .o_vs (wr_vs), .o_de (wr_de), .o_yc (wr_yc)
  );

  frame_store u_frame_store (
    .sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
    .i_wr_vs (wr_vs), .i_wr_de (wr_de), .i_wr_yc (wr_yc),
    .i_rd_vs (tg_vs), .i_rd_hs (tg_hs), .i_rd_de (tg_de),
    .o_frame_avail (frame_avail),
    .o_rd_vs (rd_vs), .o_rd_hs (rd_hs), .o_rd_de (rd_de), .o_rd_yc (rd_yc)
  );

  video_timing_gen u_video_timing_gen (
    .sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N), .i_frame_avail (frame_avail),
    .o_hs (tg_hs), .o_vs (tg_vs), .o_de (tg_de)
  );

  yuv422_to_rgb u_yuv422_to_rgb (
    .sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
    .i_vs (rd_vs), .i_hs (rd_hs), .i_de (rd_de), .i_yc (rd_yc),
    .o_vs (o_vs), .o_hs (o_hs), .o_de (o_de), .o_r (o_r), .o_g (o_g), .o_b (o_b)
  );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module tb_checker
(
  input  logic        sys_clk,
  input  logic        Sys_Rst_N,
  input  logic        i_in_vs,          // DUT input frame pulse
  input  logic        i_out_vs,         // DUT output raster
  input  logic        i_out_hs,
  input  logic        i_out_de,
  input  logic [7:0]  i_out_r,
  input  logic [7:0]  i_out_g,
  input  logic [7:0]  i_out_b,
  input  logic [23:0] i_exp [0:31],     // Expected RGB, frame A then B
  output logic        o_done,
  output int          o_fail_cnt,
  output int          o_err_cnt
);

  localparam int LINE_CYC  = `VID_H_SYNC + `VID_H_BACK + `VID_H_ACTIVE + `VID_H_FRONT;
  localparam int FRAME_CYC = LINE_CYC * (`VID_V_SYNC + `VID_V_BACK + `VID_V_ACTIVE + `VID_V_FRONT);
  localparam int NPIX      = `VID_FRAME_WORDS;

  int          cyc;                     // Negedge count
  int          in_vs_cnt;               // Input vs pulses seen
  logic        vs_q, hs_q, de_q;
  logic        vs_rise, hs_rise, hs_fall, de_rise, de_fall;
  int          hs_rise_at;
  int          de_rise_at;
  int          frame_start;
  int          pix_n, line_n;
  logic [23:0] pix [0:NPIX-1];          // Pixels of current output frame
  int          t_err [1:5];             // Errors per test
  int          pass_cnt;
  int          frame_idx, after_idx, pre_frames;
  bit          b_phase, b_seen, aborted;

  // ==========================================================================
  // Sampling and reporting helpers
  // ==========================================================================
  task automatic step;
    @(negedge sys_clk);                 // Outputs settled here
    cyc++;
    if (i_in_vs)
      in_vs_cnt++;
    vs_rise = i_out_vs && !vs_q;
    hs_rise = i_out_hs && !hs_q;
    hs_fall = !i_out_hs && hs_q;
    de_rise = i_out_de && !de_q;
    de_fall = !i_out_de && de_q;
    vs_q    = i_out_vs;
    hs_q    = i_out_hs;
    de_q    = i_out_de;
  endtask

  task automatic value_error(input int n, input string sig, input int exp_v, input int got);
    $display("error at %0t ns: %s expected %0d got %0d", $time, sig, exp_v, got);
    t_err[n]++;
  endtask

  task automatic pixel_error(input int n, input string sig, input int idx,
                             input int exp_v, input int got);
    $display("error at %0t ns: %s pixel %0d expected %0d got %0d", $time, sig, idx, exp_v, got);
    t_err[n]++;
  endtask

  task automatic flag(input int n, input string msg);
    $display("failure at %0t ns: %s", $time, msg);
    t_err[n]++;
  endtask

  task automatic abort_run(input int n, input string msg);
    flag(n, msg);
    aborted = 1'b1;
  endtask

  task automatic report_test(input int n, input string name);
    if (t_err[n] == 0)
    begin
      $display("test %0d %s: pass", n, name);
      pass_cnt++;
    end
    else
    begin
      $display("test %0d %s: fail with %0d errors", n, name, t_err[n]);
      o_fail_cnt++;
    end
  endtask

  function automatic bit frame_matches(input int base);
    if (pix_n != NPIX)
      return 1'b0;
    for (int i = 0; i < NPIX; i++)
      if (pix[i] !== i_exp[base+i])
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic report_pixels(input int n, input int base);
    for (int i = 0; i < NPIX; i++)
    begin
      if (pix[i][23:16] !== i_exp[base+i][23:16])
        pixel_error(n, "o_r", i, i_exp[base+i][23:16], pix[i][23:16]);
      if (pix[i][15:8] !== i_exp[base+i][15:8])
        pixel_error(n, "o_g", i, i_exp[base+i][15:8], pix[i][15:8]);
      if (pix[i][7:0] !== i_exp[base+i][7:0])
        pixel_error(n, "o_b", i, i_exp[base+i][7:0], pix[i][7:0]);
    end
  endtask

  // ==========================================================================
  // Raster bookkeeping for one sampled cycle
  // ==========================================================================
  task automatic scan_cycle;
    if (hs_rise)
    begin
      if (hs_rise_at >= 0 && cyc - hs_rise_at != LINE_CYC)
        value_error(2, "o_hs rise spacing", LINE_CYC, cyc - hs_rise_at);
      hs_rise_at = cyc;
    end
    if (hs_fall && hs_rise_at >= 0 && cyc - hs_rise_at != `VID_H_SYNC)
      value_error(2, "o_hs width", `VID_H_SYNC, cyc - hs_rise_at);
    if (de_rise)
      de_rise_at = cyc;
    if (de_fall)
    begin
      line_n++;
      if (cyc - de_rise_at != `VID_H_ACTIVE)
        value_error(2, "o_de run length", `VID_H_ACTIVE, cyc - de_rise_at);
    end
    if (i_out_de)
    begin
      if (pix_n < NPIX)
        pix[pix_n] = {i_out_r, i_out_g, i_out_b};
      pix_n++;
    end
  endtask

  // Sort one finished frame into tests 3, 4 and 5
  task automatic judge_frame;
    bit match_a;
    bit match_b;
    match_a = frame_matches(0);
    match_b = frame_matches(NPIX);
    if (cyc - frame_start != FRAME_CYC)
      value_error(2, "o_vs rise spacing", FRAME_CYC, cyc - frame_start);
    if (pix_n != NPIX)
      value_error(2, "o_de cycles per frame", NPIX, pix_n);
    if (line_n != `VID_V_ACTIVE)
      value_error(2, "active lines per frame", `VID_V_ACTIVE, line_n);
    if (frame_idx == 0)
    begin
      if (!match_a)
        report_pixels(3, 0);
      report_test(3, "colour round trip");
    end
    else if (!b_phase)
    begin
      if (!match_a)
        report_pixels(4, 0);
      pre_frames++;
    end
    else if (match_b)
      b_seen = 1'b1;
    else if (match_a)
    begin
      if (b_seen)
        flag(5, "output went back to frame A after showing frame B");
      else if (after_idx >= 2)
        flag(5, "frame B not shown by the second frame after its vs pulse");
    end
    else
      flag(5, "output frame matches neither frame A nor frame B");
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial
  begin
    int  k;
    bit  de_bad, hs_bad, vs_bad;
    o_done     = 1'b0;
    o_fail_cnt = 0;
    o_err_cnt  = 0;
    cyc        = 0;
    in_vs_cnt  = 0;
    {vs_q, hs_q, de_q} = 3'b000;
    hs_rise_at = -1;
    de_rise_at = 0;
    pass_cnt   = 0;
    frame_idx  = 0;
    after_idx  = 0;
    pre_frames = 0;
    b_seen     = 1'b0;
    aborted    = 1'b0;
    {de_bad, hs_bad, vs_bad} = 3'b000;
    for (k = 1; k <= 5; k++)
      t_err[k] = 0;

    k = 0;
    while (!Sys_Rst_N && k < 100)       // Reset release
    begin
      step();
      k++;
    end
    if (!Sys_Rst_N)
      abort_run(1, "reset never released");

    k = 0;
    while (!aborted && in_vs_cnt < 2 && k < 2000)   // Idle until frame A is complete
    begin
      step();
      k++;
      if (i_out_de && !de_bad)
      begin
        value_error(1, "o_de", 0, 1);
        de_bad = 1'b1;
      end
      if (i_out_hs && !hs_bad)
      begin
        value_error(1, "o_hs", 0, 1);
        hs_bad = 1'b1;
      end
      if (i_out_vs && !vs_bad)
      begin
        value_error(1, "o_vs", 0, 1);
        vs_bad = 1'b1;
      end
    end
    if (!aborted && in_vs_cnt < 2)
      abort_run(1, "second input vs pulse never arrived");
    report_test(1, "reset and idle");

    k = 0;
    vs_rise = 1'b0;
    while (!aborted && !vs_rise && k < 400)
    begin
      step();
      k++;
    end
    if (!aborted && !vs_rise)
      abort_run(2, "output raster never started");

    while (!aborted && after_idx < 3)
    begin
      b_phase = (in_vs_cnt >= 3);       // Frame B completed before this frame
      if (b_phase)
      begin
        after_idx++;
        if (after_idx == 1)
        begin
          if (pre_frames < 1)
            flag(4, "no repeated frame seen while frame B was written");
          report_test(4, "repeat until new frame");
        end
      end
      pix_n       = 0;
      line_n      = 0;
      frame_start = cyc;
      scan_cycle();
      k = 0;
      vs_rise = 1'b0;
      while (!vs_rise && k < 2 * FRAME_CYC)
      begin
        step();
        k++;
        if (!vs_rise)
          scan_cycle();
      end
      if (!vs_rise)
        abort_run(2, "o_vs stopped pulsing");
      else
        judge_frame();
      frame_idx++;
      if (frame_idx > 40)
        abort_run(5, "closing input vs pulse never arrived");
    end

    report_test(2, "raster timing");
    report_test(5, "bank swap");
    if (after_idx < 1)
      o_fail_cnt++;                     // Test 4 never closed
    for (k = 1; k <= 5; k++)
      o_err_cnt += t_err[k];
    $display("tests passed %0d failed %0d errors %0d", pass_cnt, o_fail_cnt, o_err_cnt);
    o_done = 1'b1;
  end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

  logic        sys_clk;
  logic        Sys_Rst_N;
  logic        i_vs;
  logic        i_de;
  logic [7:0]  i_r, i_g, i_b;
  logic        o_vs, o_hs, o_de;
  logic [7:0]  o_r, o_g, o_b;
  logic [23:0] stim_rgb [0:31];        // Input pixels of frame A then frame B
  logic [23:0] exp_rgb  [0:31];        // Expected output pixels
  logic [7:0]  lfsr;                   // Gap generator state
  logic        chk_done;
  int          chk_fail;
  int          chk_err;
  bit          bad;                    // Stimulus side failure

  video_top u_dut (
    .sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
    .i_vs (i_vs), .i_de (i_de), .i_r (i_r), .i_g (i_g), .i_b (i_b),
    .o_vs (o_vs), .o_hs (o_hs), .o_de (o_de), .o_r (o_r), .o_g (o_g), .o_b (o_b)
  );

  tb_checker u_checker (
    .sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N), .i_in_vs (i_vs),
    .i_out_vs (o_vs), .i_out_hs (o_hs), .i_out_de (o_de),
    .i_out_r (o_r), .i_out_g (o_g), .i_out_b (o_b), .i_exp (exp_rgb),
    .o_done (chk_done), .o_fail_cnt (chk_fail), .o_err_cnt (chk_err)
  );

  always #2 sys_clk = ~sys_clk;        // 4 ns period

  // Galois LFSR for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    if (s[0])
      return (s >> 1) ^ 8'hB8;
    else
      return s >> 1;
  endfunction

  // ==========================================================================
  // Stimulus file and drivers
  // ==========================================================================
  task automatic load_stimulus;
    int fd, code, n, tries;
    int r, g, b, er, eg, eb;
    logic [8*128-1:0] skip_line;
    n     = 0;
    tries = 0;
    fd    = $fopen("video_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open video_stimulus.txt");
      bad = 1'b1;
      return;
    end
    while (n < 32 && tries < 80 && !$feof(fd))
    begin
      code = $fscanf(fd, "%d %d %d %d %d %d", r, g, b, er, eg, eb);
      if (code == 6)
      begin
        stim_rgb[n] = {r[7:0], g[7:0], b[7:0]};
        exp_rgb[n]  = {er[7:0], eg[7:0], eb[7:0]};
        n++;
      end
      else
        code = $fgets(skip_line, fd);  // Header line
      tries++;
    end
    $fclose(fd);
    if (n != 32)
    begin
      $display("stimulus file holds %0d pixels instead of 32", n);
      bad = 1'b1;
    end
  endtask

  task automatic send_pixel(input int idx);
    int gap;
    int k;
    gap = 0;
    for (k = 0; k < 2; k++)            // One LFSR step per bit
    begin
      gap  = (gap << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    for (k = 0; k < gap; k++)
    begin
      @(posedge sys_clk);
      #1;
      i_de = 1'b0;
    end
    @(posedge sys_clk);
    #1;
    i_de = 1'b1;
    {i_r, i_g, i_b} = stim_rgb[idx];
  endtask

  task automatic end_burst;
    @(posedge sys_clk);
    #1;
    i_de = 1'b0;
  endtask

  task automatic send_vs;
    @(posedge sys_clk);
    #1;
    i_de = 1'b0;
    i_vs = 1'b1;                       // One cycle pulse
    @(posedge sys_clk);
    #1;
    i_vs = 1'b0;
  endtask

  task automatic wait_out_de;
    int k;
    k = 0;
    while (!o_de && k < 400)
    begin
      @(negedge sys_clk);
      k++;
    end
    if (!o_de)
    begin
      $display("timeout waiting for an output pixel");
      bad = 1'b1;
    end
  endtask

  task automatic wait_out_vs_rises(input int cnt);
    int   k;
    int   seen;
    logic prev;
    k    = 0;
    seen = 0;
    prev = o_vs;
    while (seen < cnt && k < 400)
    begin
      @(negedge sys_clk);
      if (o_vs && !prev)
        seen++;
      prev = o_vs;
      k++;
    end
    if (seen < cnt)
    begin
      $display("timeout waiting for output vs pulses");
      bad = 1'b1;
    end
  endtask

  task automatic wait_checker;
    int k;
    k = 0;
    while (!chk_done && k < 2000)
    begin
      @(posedge sys_clk);
      k++;
    end
    if (!chk_done)
      $display("timeout waiting for the checker to finish");
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    int i;
    sys_clk   = 1'b0;
    Sys_Rst_N = 1'b0;
    i_vs      = 1'b0;
    i_de      = 1'b0;
    i_r       = 8'd0;
    i_g       = 8'd0;
    i_b       = 8'd0;
    lfsr      = 8'd81;
    bad       = 1'b0;
    load_stimulus();
    repeat (5) @(posedge sys_clk);
    #1;
    Sys_Rst_N = 1'b1;
    if (!bad)
    begin
      send_vs();                       // Opens frame A
      for (i = 0; i < 16; i++)
        send_pixel(i);
      send_vs();                       // Completes A and opens B
      wait_out_de();
    end
    if (!bad)
    begin
      for (i = 16; i < 32; i++)
        send_pixel(i);
      end_burst();
      wait_out_vs_rises(2);            // Output keeps repeating A meanwhile
    end
    if (!bad)
      wait_out_de();                   // Closing pulse lands inside active video
    if (!bad)
    begin
      send_vs();                       // Completes B
      wait_checker();
    end
    if (bad || !chk_done || chk_fail != 0 || chk_err != 0)
      $display("TEST FAILED");
    else
      $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== video_stimulus.txt ====
# Columns: in_r in_g in_b exp_r exp_g exp_b (decimal)
# Lines 1-16 are frame A, lines 17-32 frame B, raster order
0 0 0 0 0 0
0 0 0 0 0 0
255 255 255 255 255 255
255 255 255 255 255 255
255 0 0 255 1 0
255 0 0 255 1 0
0 255 0 0 254 0
0 255 0 0 254 0
0 0 255 0 0 255
0 0 255 0 0 255
128 128 128 128 128 128
128 128 128 128 128 128
255 0 0 48 106 0
0 0 255 0 59 0
0 0 0 0 0 0
255 255 255 255 255 255
255 255 255 255 255 255
0 0 0 0 0 0
128 128 128 128 128 128
128 128 128 128 128 128
0 0 255 0 0 255
0 0 255 0 0 255
255 0 0 48 106 0
0 0 255 0 59 0
0 255 0 0 254 0
0 255 0 0 254 0
255 0 0 255 1 0
255 0 0 255 1 0
255 255 255 255 255 255
255 255 255 255 255 255
0 0 0 0 0 0
0 0 0 0 0 0

// ==== sim.f ====
+incdir+.
video_pkg.sv
rgb_to_yuv422.sv
frame_store.sv
video_timing_gen.sv
yuv422_to_rgb.sv
video_top.sv
tb_checker.sv
tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame buffer video path simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f sim.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST PASSED" sim.log
